// ==== rtl/cell_memory.sv ====
//////////////////////////////////////////////////////////////////////
// two-bank row memory, pass and video read ports, one write port
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module cell_memory (
	input  logic              clk,
	input  life_pkg::mem_rd_t rd_cmd,    // pass reads
	input  life_pkg::mem_rd_t vid_cmd,   // video reads
	input  life_pkg::mem_wr_t wr_cmd,    // init or write-back
	output life_pkg::row_t    rd_data,
	output life_pkg::row_t    vid_data
);

	// two full boards, the pass reads one and writes the other
	life_pkg::row_t mem [2][`LIFE_DEPTH];

	// both read ports behave the same, so handle them as a small array
	life_pkg::mem_rd_t   port_cmd [2];
	life_pkg::mem_addr_t addr_q [2];                     // registered address
	life_pkg::row_t      data_q [2][`LIFE_MEM_LAT-1];    // output register chain

	assign port_cmd[0] = rd_cmd;
	assign port_cmd[1] = vid_cmd;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_cmd.en) begin
			mem[wr_cmd.addr.bank][wr_cmd.addr.row] <= wr_cmd.data;   // 1 cycle write
		end
		for (int p = 0; p < 2; p++) begin
			if (port_cmd[p].en) begin
				addr_q[p] <= port_cmd[p].addr;   // holds last address when idle
			end
			data_q[p][0] <= mem[addr_q[p].bank][addr_q[p].row];
			// extra output stages when latency is above 2
			for (int s = 1; s < `LIFE_MEM_LAT - 1; s++) begin
				data_q[p][s] <= data_q[p][s-1];
			end
		end
	end

	assign rd_data  = data_q[0][`LIFE_MEM_LAT-2];
	assign vid_data = data_q[1][`LIFE_MEM_LAT-2];

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// pass reads come from the active bank, write-back goes to the other
	// one, so the bank swap in the sequencer must keep them apart
	a_no_rd_wr_clash : assert property (@(posedge clk)
		rd_cmd.en && wr_cmd.en |-> rd_cmd.addr != wr_cmd.addr)
		else $error("pass read and write hit the same row");

endmodule

// ==== rtl/generation_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// enable alignment to memory latency and the chain of life stages
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module generation_pipeline #(
	parameter int GENS = `LIFE_GENS   // generations per pass, 1 or more
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           shift,        // same cycle as the memory read
	input  life_pkg::row_t row_in,       // memory read data
	output life_pkg::row_t row_out,      // last stage result
	output logic           row_strobe    // row_out is new this cycle
);

	// read strobe delayed to line up with rd_data
	logic [`LIFE_MEM_LAT-1:0] shift_del;
	logic                     en;          // global stage enable

	// chain[g] feeds stage g, chain[GENS] is the pipeline output
	life_pkg::row_t chain [GENS+1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shift_del  <= '0;
			row_strobe <= 1'b0;
		end else begin
			shift_del  <= {shift_del[`LIFE_MEM_LAT-2:0], shift};
			row_strobe <= en;   // result registered on en is valid one cycle on
		end
	end

	assign en = shift_del[`LIFE_MEM_LAT-1];

	//////////////////////////////////////////////////////////////////////
	// stage chain
	//////////////////////////////////////////////////////////////////////

	assign chain[0] = row_in;

	for (genvar g = 0; g < GENS; g++) begin : g_stage
		generation_stage generation_stage_inst (
			.clk      (clk),
			.en       (en),
			.row_in   (chain[g]),
			.row_next (chain[g+1])
		);
	end

	assign row_out = chain[GENS];

endmodule

// ==== rtl/generation_stage.sv ====
//////////////////////////////////////////////////////////////////////
// one life generation over a streaming window of board rows
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module generation_stage (
	input  logic           clk,
	input  logic           en,         // one row per enable
	input  life_pkg::row_t row_in,     // newest row, below the centre
	output life_pkg::row_t row_next    // next generation of the centre row
);

	// window is row_in plus the two rows before it
	life_pkg::row_t centre;   // row being evaluated
	life_pkg::row_t above;    // row before the centre

	// per-column vertical tally, 0..3
	logic [1:0] vsum [`LIFE_WIDTH];

	// 3x3 tally incl. the cell itself, 0..9
	logic [3:0] nsum [`LIFE_WIDTH];

	life_pkg::row_t next_row;

	//////////////////////////////////////////////////////////////////////
	// adders
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int x = 0; x < `LIFE_WIDTH; x++) begin
			vsum[x] = {1'b0, above[x]} +
			          {1'b0, centre[x]} +
			          {1'b0, row_in[x]};
		end
	end

	// horizontal sum of three vertical tallies, wraps at both edges
	always_comb begin
		for (int x = 0; x < `LIFE_WIDTH; x++) begin
			int left;
			int right;
			left  = (x == 0) ? `LIFE_WIDTH - 1 : x - 1;     // left wrap
			right = (x == `LIFE_WIDTH - 1) ? 0 : x + 1;     // right wrap
			nsum[x] = {2'b00, vsum[left]} +
			          {2'b00, vsum[x]} +
			          {2'b00, vsum[right]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// rule
	//////////////////////////////////////////////////////////////////////

	// total of 3 gives birth or survival with 2 neighbours,
	// total of 4 keeps a live cell with 3 neighbours
	always_comb begin
		for (int x = 0; x < `LIFE_WIDTH; x++) begin
			next_row[x] = (nsum[x] == 4'd3) ||
			              ((nsum[x] == 4'd4) && centre[x]);
		end
	end

	// window shift and result share the same enable,
	// so the centre of enable k leaves as row_next at enable k
	always_ff @(posedge clk) begin
		if (en) begin
			above    <= centre;
			centre   <= row_in;
			row_next <= next_row;
		end
	end

endmodule

// ==== rtl/life_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared row, address and memory command types for the life engine
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

package life_pkg;

	// one board row, bit x is column x
	typedef logic [`LIFE_WIDTH-1:0] row_t;

	// row index within one bank
	typedef logic [`LIFE_ROW_BITS-1:0] row_addr_t;

	// full memory address, bank selects which copy of the board
	typedef struct packed {
		logic      bank;   // 0 or 1
		row_addr_t row;
	} mem_addr_t;

	// read request, one per cycle
	typedef struct packed {
		logic      en;     // read strobe
		mem_addr_t addr;
	} mem_rd_t;

	// write request, stored at the next edge
	typedef struct packed {
		logic      en;     // write strobe
		mem_addr_t addr;
		row_t      data;
	} mem_wr_t;

endpackage

// ==== rtl/life_settings.svh ====
//////////////////////////////////////////////////////////////////////
// board geometry, generations per pass and row memory read latency
//////////////////////////////////////////////////////////////////////

`ifndef LIFE_SETTINGS_SVH
`define LIFE_SETTINGS_SVH

// board size, one memory word per row
`define LIFE_WIDTH 16     // cells per row
`define LIFE_DEPTH 16     // rows per board
`define LIFE_ROW_BITS 4   // row index width, 2**bits >= depth

// engine depth
`define LIFE_GENS 2       // generation stages chained per pass

// row memory
// registered address plus registered output, so 2 is the minimum
`define LIFE_MEM_LAT 2

`endif

// ==== rtl/life_top.sv ====
//////////////////////////////////////////////////////////////////////
// life engine top: sequencer, generation pipeline, memory, video read
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module life_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,       // pulse, begins one pass
	output logic                busy,        // high for the whole pass
	input  logic                init_we,     // board load, idle only
	input  life_pkg::row_addr_t init_addr,
	input  life_pkg::row_t      init_data,
	input  logic                ld,          // video row read strobe
	input  life_pkg::row_addr_t ld_addr,
	output life_pkg::row_t      dout         // video row, holds between reads
);

	life_pkg::mem_rd_t rd_cmd;
	life_pkg::mem_rd_t vid_cmd;
	life_pkg::mem_wr_t wr_cmd;
	life_pkg::row_t    rd_data;
	life_pkg::row_t    vid_data;
	life_pkg::row_t    row_out;
	logic              row_strobe;
	logic              bank;

	logic [`LIFE_MEM_LAT-1:0] ld_del;   // ld aligned to vid_data

	//////////////////////////////////////////////////////////////////////
	// engine
	//////////////////////////////////////////////////////////////////////

	pass_sequencer pass_sequencer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.row_strobe (row_strobe),
		.row_out    (row_out),
		.init_we    (init_we),
		.init_addr  (init_addr),
		.init_data  (init_data),
		.busy       (busy),
		.bank       (bank),
		.rd_cmd     (rd_cmd),
		.wr_cmd     (wr_cmd)
	);

	generation_pipeline #(
		.GENS (`LIFE_GENS)
	) generation_pipeline_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.shift      (rd_cmd.en),   // read strobe doubles as shift
		.row_in     (rd_data),
		.row_out    (row_out),
		.row_strobe (row_strobe)
	);

	cell_memory cell_memory_inst (
		.clk      (clk),
		.rd_cmd   (rd_cmd),
		.vid_cmd  (vid_cmd),
		.wr_cmd   (wr_cmd),
		.rd_data  (rd_data),
		.vid_data (vid_data)
	);

	//////////////////////////////////////////////////////////////////////
	// video read port
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		vid_cmd.en        = ld;
		vid_cmd.addr.bank = bank;   // always the current board
		vid_cmd.addr.row  = ld_addr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ld_del <= '0;
		end else begin
			ld_del <= {ld_del[`LIFE_MEM_LAT-2:0], ld};
		end
	end

	// latch one row, dout changes LIFE_MEM_LAT+1 cycles after ld
	always_ff @(posedge clk) begin
		if (ld_del[`LIFE_MEM_LAT-1]) begin
			dout <= vid_data;
		end
	end

endmodule

// ==== rtl/pass_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// pass control: wrapped row reads, write-back, bank swap, init mux
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module pass_sequencer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,        // pulse, ignored while busy
	input  logic                row_strobe,   // new row_out from the pipeline
	input  life_pkg::row_t      row_out,
	input  logic                init_we,
	input  life_pkg::row_addr_t init_addr,
	input  life_pkg::row_t      init_data,
	output logic                busy,
	output logic                bank,         // active bank
	output life_pkg::mem_rd_t   rd_cmd,
	output life_pkg::mem_wr_t   wr_cmd
);

	// GENS halo rows on each side, plus GENS-1 flush reads because each
	// stage hands its row to the next one enable late
	localparam int RD_TOTAL = `LIFE_DEPTH + 3 * `LIFE_GENS - 1;
	localparam int CW       = $clog2(RD_TOTAL + 1);

	localparam logic [CW-1:0] RD_LAST = CW'(RD_TOTAL - 1);
	localparam logic [CW-1:0] FILL    = CW'(3 * `LIFE_GENS - 1);   // strobes to drop

	localparam life_pkg::row_addr_t ROW_FIRST = life_pkg::row_addr_t'(`LIFE_DEPTH - `LIFE_GENS);
	localparam life_pkg::row_addr_t ROW_LAST  = life_pkg::row_addr_t'(`LIFE_DEPTH - 1);

	logic                rd_active;   // read phase of the pass
	logic [CW-1:0]       rd_cnt;
	life_pkg::row_addr_t rd_row;      // wraps at the bottom edge
	logic [CW-1:0]       fill_cnt;    // counts dropped strobes
	life_pkg::row_addr_t wr_row;
	logic                pass_wr;
	logic                last_wr;

	assign pass_wr = busy && row_strobe && (fill_cnt == FILL);
	assign last_wr = pass_wr && (wr_row == ROW_LAST);

	//////////////////////////////////////////////////////////////////////
	// counters and bank
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			rd_active <= 1'b0;
			rd_cnt    <= '0;
			rd_row    <= '0;
			fill_cnt  <= '0;
			wr_row    <= '0;
			bank      <= 1'b0;
		end else begin
			if (start && !busy) begin
				busy      <= 1'b1;
				rd_active <= 1'b1;
				rd_cnt    <= '0;
				rd_row    <= ROW_FIRST;   // start GENS rows above row 0
				fill_cnt  <= '0;
				wr_row    <= '0;
			end
			if (rd_active) begin
				rd_cnt <= rd_cnt + 1'b1;
				rd_row <= (rd_row == ROW_LAST) ? '0 : rd_row + 1'b1;
				if (rd_cnt == RD_LAST) begin
					rd_active <= 1'b0;
				end
			end
			if (busy && row_strobe && (fill_cnt != FILL)) begin
				fill_cnt <= fill_cnt + 1'b1;   // window still filling
			end
			if (pass_wr) begin
				wr_row <= wr_row + 1'b1;
			end
			if (last_wr) begin
				busy <= 1'b0;
				bank <= ~bank;   // new board becomes the active one
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory commands
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_cmd.en        = rd_active;
		rd_cmd.addr.bank = bank;
		rd_cmd.addr.row  = rd_row;
	end

	always_comb begin
		wr_cmd = '0;
		if (pass_wr) begin   // write-back into the inactive bank
			wr_cmd.en        = 1'b1;
			wr_cmd.addr.bank = ~bank;
			wr_cmd.addr.row  = wr_row;
			wr_cmd.data      = row_out;
		end else if (init_we && !busy) begin
			wr_cmd.en        = 1'b1;
			wr_cmd.addr.bank = bank;
			wr_cmd.addr.row  = init_addr;
			wr_cmd.data      = init_data;
		end
	end

	// the pass stays up until the last read has reached the write-back
	a_rd_in_pass : assert property (@(posedge clk) disable iff (!rst_n)
		rd_cmd.en |-> busy [*(`LIFE_MEM_LAT + 2)]);

	a_bank_at_end : assert property (@(posedge clk) disable iff (!rst_n)
		bank != $past(bank) |-> $past(last_wr) && !busy);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the life engine testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module life_tb -f verilog.f > build.log 2>&1 \
	&& ./obj_dir/Vlife_tb > sim.log 2>&1 \
	|| echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tests/life_patterns.txt ====
// word 0 is the pass count, then boards of 16 rows, four rows per line, row 0 first
// bit n of a row is column n, board 0 is loaded and each later one follows a pass
0004

// initial board with a glider in rows 13 to 15 and a blinker on row 8 over the side edge
0000 0000 0000 0000
0000 0000 0000 0000
8003 0000 0000 0000
0000 4000 8000 E000

// after pass 1
C000 0000 0000 0000
0000 0000 0000 0000
8003 0000 0000 0000
0000 0000 8000 A000

// after pass 2
C001 0000 0000 0000
0000 0000 0000 0000
8003 0000 0000 0000
0000 0000 8000 0001

// after pass 3
4001 8001 0000 0000
0000 0000 0000 0000
8003 0000 0000 0000
0000 0000 0000 0001

// after pass 4
0002 8003 0000 0000
0000 0000 0000 0000
8003 0000 0000 0000
0000 0000 0000 0001

// ==== tests/life_tb.sv ====
//////////////////////////////////////////////////////////////////////
// life engine testbench with board load, passes and row readback
//////////////////////////////////////////////////////////////////////

`include "life_settings.svh"

module life_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_PASSES = 8;
	localparam int PAT_WORDS  = 1 + `LIFE_DEPTH * (MAX_PASSES + 1);

	logic                clk;
	logic                rst_n;
	logic                start;
	logic                busy;
	logic                init_we;
	life_pkg::row_addr_t init_addr;
	life_pkg::row_t      init_data;
	logic                ld;
	life_pkg::row_addr_t ld_addr;
	life_pkg::row_t      dout;

	life_pkg::row_t pat [PAT_WORDS];   // pass count followed by boards of DEPTH rows
	int             order [`LIFE_DEPTH];   // shuffled readback order
	int             passes;
	int             cycle_cnt = 0;
	int             cycle_limit;

	life_top life_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.busy      (busy),
		.init_we   (init_we),
		.init_addr (init_addr),
		.init_data (init_data),
		.ld        (ld),
		.ld_addr   (ld_addr),
		.dout      (dout)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	// run limit scales with the number of passes in the pattern file
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout reached after %0d cycles, the tests did not finish", cycle_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "simulation ran out of cycles");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "stopping at the first failed check");
	endtask

	// drive point 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// video read of one row with dout taking the row on the third cycle
	task automatic check_row(input int row, input life_pkg::row_t exp);
		life_pkg::row_t prev;
		prev    = dout;
		ld      = 1'b1;
		ld_addr = life_pkg::row_addr_t'(row);
		next_cycle();
		ld = 1'b0;
		next_cycle();
		assert (dout === prev) else begin
			$display("ERROR at %0t: row %0d dout changed early, expected %h got %h",
				$time, row, prev, dout);
			stop_with_failure();
		end
		next_cycle();
		assert (dout === exp) else begin
			$display("ERROR at %0t: row %0d expected %h got %h", $time, row, exp, dout);
			stop_with_failure();
		end
	endtask

	// every row of one board in random order
	task automatic check_board(input int board);
		int j;
		int tmp;
		for (int i = 0; i < `LIFE_DEPTH; i++) begin
			order[i] = i;
		end
		for (int i = `LIFE_DEPTH - 1; i > 0; i--) begin
			j        = int'($urandom_range(i));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < `LIFE_DEPTH; i++) begin
			check_row(order[i], pat[1 + board * `LIFE_DEPTH + order[i]]);
		end
	endtask

	// one pass with an optional init write that must be ignored
	task automatic run_pass(input bit poke_init);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		assert (busy === 1'b1) else begin
			$display("ERROR at %0t: busy did not rise the cycle after start", $time);
			stop_with_failure();
		end
		if (poke_init) begin
			next_cycle();
			init_we   = 1'b1;   // blinker row so any damage shows on readback
			init_addr = life_pkg::row_addr_t'(8);
			init_data = 16'h5a5a;
			next_cycle();
			init_we = 1'b0;
		end
		while (busy) begin
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		life_pkg::row_t held;
		rst_n     = 1'b0;
		start     = 1'b0;
		init_we   = 1'b0;
		init_addr = '0;
		init_data = '0;
		ld        = 1'b0;
		ld_addr   = '0;
		void'($urandom(32'hcdc1a32d));
		$readmemh("tests/life_patterns.txt", pat);
		passes      = int'(pat[0]);
		cycle_limit = (passes + 1) * (`LIFE_DEPTH * 8 + 50);
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		assert (busy === 1'b0) else begin
			$display("ERROR at %0t: busy high after reset", $time);
			stop_with_failure();
		end
		for (int r = 0; r < `LIFE_DEPTH; r++) begin   // initial board
			init_we   = 1'b1;
			init_addr = life_pkg::row_addr_t'(r);
			init_data = pat[1 + r];
			next_cycle();
		end
		init_we = 1'b0;
		check_board(0);
		// overwrite the last row read so vid_data moves while dout must hold
		held      = dout;
		init_we   = 1'b1;
		init_addr = life_pkg::row_addr_t'(order[`LIFE_DEPTH - 1]);
		init_data = ~held;
		next_cycle();
		init_we = 1'b0;
		repeat (4) next_cycle();
		assert (dout === held) else begin
			$display("ERROR at %0t: dout moved without ld, expected %h got %h",
				$time, held, dout);
			stop_with_failure();
		end
		init_we   = 1'b1;   // put the board row back
		init_data = held;
		next_cycle();
		init_we = 1'b0;
		for (int p = 1; p <= passes; p++) begin
			repeat (int'($urandom_range(12, 1))) next_cycle();   // idle gap
			run_pass(p == 2);
			check_board(p);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/life_pkg.sv
rtl/cell_memory.sv
rtl/generation_stage.sv
rtl/generation_pipeline.sv
rtl/pass_sequencer.sv
rtl/life_top.sv
tests/life_tb.sv
